// ==== verilog.f ====
common/vdf_pkg.sv
poly_mod_mult/poly_carry_fold.sv
poly_mod_mult/poly_mod_reduce_hi.sv
poly_mod_mult/poly_coef_add.sv
poly_mod_mult/poly_mod_mult.sv
verilog/poly_mod_sq_wrapper.sv
verilog/mod_correct.sv
verilog/vdf_sq_top.sv
tests/tb_vdf_sq.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_vdf_sq
FILELIST = verilog.f
OBJ_DIR  = obj_dir

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tb_vdf_sq.sv ====
/*
  Self-checking random testbench for the modular squaring unit. A wide-integer
  model predicts every result, a queue holds the predictions in order, and a
  monitor on the falling edge checks value, latency and range of each output.
*/
`timescale 1ns/100ps
module tb_vdf_sq;

  localparam int                WORD_BITS    = 16;
  localparam int                NUM_WORDS    = 4;
  localparam int                I_WORD       = NUM_WORDS + 1;
  localparam int                COEF_BITS    = WORD_BITS + 1;
  localparam logic [63:0]       MODULUS      = 64'hE3B0_C442_98FC_1C15;
  localparam int                LATENCY      = 11;   // request to integer result.
  localparam int                RST_CYCLES   = 4;
  localparam int                QUIET_CYCLES = 15;   // idle window before the first word.
  localparam int                N_BACK       = 200;
  localparam int                N_MIX        = 200;
  localparam int                N_EDGE       = 18;   // nine edge operands in both modes.
  localparam int                GAP_SLOTS    = 300;
  localparam int                TOTAL_SLOTS  = RST_CYCLES + QUIET_CYCLES + N_BACK + N_MIX
                                               + N_EDGE + GAP_SLOTS + 1;
  localparam int                TIMEOUT      = TOTAL_SLOTS + LATENCY + 50;

  logic              i_clk;
  logic              i_rst;
  vdf_pkg::sq_req_t  req;
  vdf_pkg::int_rsp_t rsp;

  logic [255:0]      exp_q[$];   // expected results in issue order.
  string             name_q[$];  // test name of each word in flight.
  int                cyc_q[$];   // cycle in which each word was driven.
  int                cyc      = 0;
  vdf_pkg::coef_vec_t edge_ops [9];

  vdf_sq_top #(
    .WORD_BITS ( WORD_BITS ),
    .NUM_WORDS ( NUM_WORDS ),
    .MODULUS   ( MODULUS   )
  ) DUT (
    .i_clk ( i_clk ),
    .i_rst ( i_rst ),
    .i_req ( req   ),
    .o_rsp ( rsp   )
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;  // 40 ns period.
  end

  // prints the reason, then the fail line, and stops the run.
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopping on first error");
  endtask

  task automatic check_value(input string name, input logic [255:0] exp,
                             input logic [255:0] act);
    if (exp !== act) begin
      $display("Mismatch in %s: expected %0h, actual %0h", name, exp, act);
      abort_run("value check failed");
    end
  endtask

  // coefficient i carries weight 2**(16*i), summed in wide arithmetic.
  function automatic logic [255:0] operand_value(input vdf_pkg::coef_vec_t d);
    logic [255:0] v;
    v = '0;
    for (int i = 0; i < I_WORD; i++) v = v + (256'(d[i]) << (WORD_BITS*i));
    return v;
  endfunction

  function automatic logic [255:0] expected_result(input vdf_pkg::coef_vec_t d,
                                                   input logic ro);
    logic [255:0] v;
    v = operand_value(d);
    if (ro) return v % 256'(MODULUS);      // reduce only.
    else    return (v * v) % 256'(MODULUS);
  endfunction

  // plain words in the low entries, everything above 2**64 in the top one.
  function automatic vdf_pkg::coef_vec_t coefs_from_int(input logic [255:0] v);
    vdf_pkg::coef_vec_t d;
    for (int i = 0; i < I_WORD-1; i++) d[i] = COEF_BITS'(v[WORD_BITS*i +: WORD_BITS]);
    d[I_WORD-1] = COEF_BITS'(v >> (WORD_BITS*(I_WORD-1)));
    return d;
  endfunction

  function automatic vdf_pkg::coef_vec_t random_operand();
    vdf_pkg::coef_vec_t d;
    for (int i = 0; i < I_WORD; i++) d[i] = COEF_BITS'($urandom);  // full redundant range.
    return d;
  endfunction

  task automatic send_word(input string name, input vdf_pkg::coef_vec_t d, input logic ro);
    @(negedge i_clk);
    req.val         = 1'b1;
    req.reduce_only = ro;
    req.dat         = d;
    exp_q.push_back(expected_result(d, ro));
    name_q.push_back(name);
    cyc_q.push_back(cyc);
  endtask

  // idle slots carry random payload, which must be ignored.
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge i_clk);
      req.val         = 1'b0;
      req.reduce_only = 1'($urandom);
      req.dat         = random_operand();
    end
  endtask

  always @(posedge i_clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT) abort_run("timeout: the outputs did not drain in time");
  end

  // outputs settle after the rising edge and are read on the falling one.
  always @(negedge i_clk) begin
    if (i_rst) begin
      if (cyc > 0) check_value("reset valid", 256'(0), 256'(rsp.val));
    end else if (rsp.val) begin
      if (exp_q.size() == 0) begin
        abort_run("output valid while no word was in flight");
      end else begin
        check_value({name_q[0], " below modulus"}, 256'(1), 256'(rsp.dat < MODULUS));
        check_value(name_q[0], exp_q[0], 256'(rsp.dat));
        check_value({name_q[0], " latency"}, 256'(LATENCY), 256'(cyc - cyc_q[0]));
        void'(exp_q.pop_front());
        void'(name_q.pop_front());
        void'(cyc_q.pop_front());
      end
    end
  end

  initial begin
    void'($urandom(40));  // one seed for the whole run.
    i_rst = 1'b1;
    req   = '0;
    repeat (RST_CYCLES) @(negedge i_clk);
    i_rst = 1'b0;
    idle_cycles(QUIET_CYCLES);  // nothing may come out here.

    for (int n = 0; n < N_BACK; n++) send_word("back_to_back", random_operand(), 1'b0);
    for (int n = 0; n < N_MIX; n++) send_word("mixed", random_operand(), 1'($urandom));

    edge_ops[0] = coefs_from_int(256'(0));
    edge_ops[1] = coefs_from_int(256'(1));
    edge_ops[2] = coefs_from_int(256'(MODULUS) - 256'(1));
    edge_ops[3] = coefs_from_int(256'(MODULUS));
    edge_ops[4] = coefs_from_int(256'(MODULUS) + 256'(1));
    edge_ops[5] = coefs_from_int((256'(1) << 64) - 256'(1));
    edge_ops[6] = coefs_from_int(256'(1) << 64);
    edge_ops[7] = '1;                                          // every coefficient at its max.
    edge_ops[8] = coefs_from_int(256'(MODULUS) * 256'(2) + 256'(5));
    for (int n = 0; n < 9; n++) begin
      send_word("edge", edge_ops[n], 1'b0);
      send_word("edge", edge_ops[n], 1'b1);
    end

    // about one slot in three stays idle.
    for (int n = 0; n < GAP_SLOTS; n++) begin
      if ($urandom_range(0, 2) == 0) idle_cycles(1);
      else                          send_word("gaps", random_operand(), 1'($urandom));
    end
    idle_cycles(1);

    while (exp_q.size() != 0) @(negedge i_clk);
    idle_cycles(LATENCY);  // no stray outputs once drained.
    $display("sim passed");
    $finish;
  end

endmodule

// ==== verilog/vdf_sq_top.sv ====
/*
  Top level of the modular squaring unit. Sets the default size and modulus
  and chains the squaring wrapper into the correction stage, eleven cycles
  from request to integer result.
*/
`timescale 1ns/100ps
module vdf_sq_top #(
  parameter int                             WORD_BITS       = 16,
  parameter int                             NUM_WORDS       = 4,
  parameter logic [WORD_BITS*NUM_WORDS-1:0] MODULUS         = 64'hE3B0_C442_98FC_1C15,
  parameter int                             REDUN_WORD_BITS = 1,
  parameter int                             I_WORD          = NUM_WORDS + 1,
  parameter int                             COEF_BITS       = WORD_BITS + REDUN_WORD_BITS
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  vdf_pkg::sq_req_t  i_req,
  output vdf_pkg::int_rsp_t o_rsp
);

  vdf_pkg::sq_rsp_t sq_rsp;  // redundant result, nine cycles after the request.

  poly_mod_sq_wrapper #(
    .WORD_BITS ( WORD_BITS ),
    .NUM_WORDS ( NUM_WORDS ),
    .MODULUS   ( MODULUS   ),
    .I_WORD    ( I_WORD    ),
    .COEF_BITS ( COEF_BITS )
  ) u_sq (
    .i_clk ( i_clk  ),
    .i_rst ( i_rst  ),
    .i_req ( i_req  ),
    .o_rsp ( sq_rsp )
  );

  mod_correct #(
    .WORD_BITS ( WORD_BITS ),
    .NUM_WORDS ( NUM_WORDS ),
    .MODULUS   ( MODULUS   ),
    .I_WORD    ( I_WORD    ),
    .COEF_BITS ( COEF_BITS )
  ) u_correct (
    .i_clk ( i_clk  ),
    .i_rst ( i_rst  ),
    .i_rsp ( sq_rsp ),
    .o_rsp ( o_rsp  )
  );

endmodule

// ==== verilog/mod_correct.sv ====
/*
  Final correction of the redundant result. Stage one builds the integer and
  estimates its quotient by the modulus; stage two removes that multiple and
  makes one conditional subtract, leaving a value below the modulus.
*/
`timescale 1ns/100ps
module mod_correct #(
  parameter int                             WORD_BITS = 16,
  parameter int                             NUM_WORDS = 4,
  parameter logic [WORD_BITS*NUM_WORDS-1:0] MODULUS   = 64'hE3B0_C442_98FC_1C15,
  parameter int                             I_WORD    = NUM_WORDS + 1,
  parameter int                             COEF_BITS = WORD_BITS + 1
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  vdf_pkg::sq_rsp_t  i_rsp,
  output vdf_pkg::int_rsp_t o_rsp
);

  localparam int COL_BITS = 2*COEF_BITS + $clog2(I_WORD) + 1;
  localparam int ACC_BITS = COL_BITS + WORD_BITS + $clog2(I_WORD) + 1;
  localparam int INT_BITS = WORD_BITS*(I_WORD-1) + ACC_BITS;  // integer before reduction.
  localparam int MOD_W    = $clog2(MODULUS);                  // bit length of an odd modulus.
  localparam int MU_BITS  = INT_BITS - MOD_W + 2;
  localparam int REM_BITS = MOD_W + 1;                        // remainders stay below 2*MODULUS.
  localparam logic [MU_BITS-1:0] MU = MU_BITS'(vdf_pkg::barrett_mu(INT_BITS, 128'(MODULUS)));

  logic [INT_BITS-1:0]         x;
  logic [INT_BITS+MU_BITS-1:0] x_mu;
  logic [REM_BITS-1:0]         x_lo_q;  // only the low bits matter once the quotient is known.
  logic [MU_BITS-1:0]          q_q;
  logic                        val_q;
  logic [REM_BITS-1:0]         qm, rem, rem_fix;

  // the top coefficient is wide, so it simply lands above the lower words.
  always_comb begin
    x = '0;
    for (int j = 0; j < I_WORD; j++) x = x + (INT_BITS'(i_rsp.dat[j]) << (WORD_BITS*j));
  end

  // mu is floor(2**INT_BITS / MODULUS), so the estimate is at most one short.
  assign x_mu = (INT_BITS+MU_BITS)'(x) * (INT_BITS+MU_BITS)'(MU);

  always_ff @(posedge i_clk) begin
    x_lo_q <= x[REM_BITS-1:0];
    q_q    <= MU_BITS'(x_mu >> INT_BITS);
    if (i_rst) val_q <= 1'b0;
    else       val_q <= i_rsp.val;
  end

  // low bits of q*MODULUS are enough because the true remainder is small.
  assign qm      = REM_BITS'(q_q) * REM_BITS'(MODULUS);
  assign rem     = x_lo_q - qm;
  assign rem_fix = (rem >= REM_BITS'(MODULUS)) ? rem - REM_BITS'(MODULUS) : rem;

  always_ff @(posedge i_clk) begin
    o_rsp.dat <= (WORD_BITS*NUM_WORDS)'(rem_fix);
    if (i_rst) o_rsp.val <= 1'b0;
    else       o_rsp.val <= val_q;
  end

endmodule

// ==== verilog/poly_mod_sq_wrapper.sv ====
/*
  Pipelines requests into the squaring multiplier and its results out again,
  three registers on each side. Nine cycles in total.
*/
`timescale 1ns/100ps
module poly_mod_sq_wrapper #(
  parameter int                             WORD_BITS = 16,
  parameter int                             NUM_WORDS = 4,
  parameter logic [WORD_BITS*NUM_WORDS-1:0] MODULUS   = 64'hE3B0_C442_98FC_1C15,
  parameter int                             I_WORD    = NUM_WORDS + 1,
  parameter int                             COEF_BITS = WORD_BITS + 1
) (
  input  logic             i_clk,
  input  logic             i_rst,
  input  vdf_pkg::sq_req_t i_req,
  output vdf_pkg::sq_rsp_t o_rsp
);

  localparam int PIPES = 3;

  vdf_pkg::sq_req_t [PIPES-1:0] req_q;  // stage 0 is nearest the input.
  vdf_pkg::sq_rsp_t [PIPES-1:0] rsp_q;  // stage 0 is nearest the multiplier.
  vdf_pkg::sq_rsp_t             mult_rsp;

  always_ff @(posedge i_clk) begin
    for (int s = 0; s < PIPES; s++) begin
      req_q[s].dat         <= (s == 0) ? i_req.dat         : req_q[s-1].dat;
      req_q[s].reduce_only <= (s == 0) ? i_req.reduce_only : req_q[s-1].reduce_only;
      rsp_q[s].dat         <= (s == 0) ? mult_rsp.dat      : rsp_q[s-1].dat;
    end
    if (i_rst) begin
      for (int s = 0; s < PIPES; s++) begin
        req_q[s].val <= 1'b0;
        rsp_q[s].val <= 1'b0;
      end
    end else begin
      for (int s = 0; s < PIPES; s++) begin
        req_q[s].val <= (s == 0) ? i_req.val    : req_q[s-1].val;
        rsp_q[s].val <= (s == 0) ? mult_rsp.val : rsp_q[s-1].val;
      end
    end
  end

  poly_mod_mult #(
    .WORD_BITS ( WORD_BITS ),
    .NUM_WORDS ( NUM_WORDS ),
    .MODULUS   ( MODULUS   ),
    .I_WORD    ( I_WORD    ),
    .COEF_BITS ( COEF_BITS )
  ) u_mult (
    .i_clk ( i_clk          ),
    .i_rst ( i_rst          ),
    .i_req ( req_q[PIPES-1] ),
    .o_rsp ( mult_rsp       )
  );

  assign o_rsp = rsp_q[PIPES-1];

endmodule

// ==== poly_mod_mult/poly_mod_mult.sv ====
/*
  Squares the redundant operand into product columns, or passes it through in
  reduce-only mode, then splits the columns between the low carry fold and the
  high residue reduction, whose results are combined by the coefficient adder.
  Three cycles of latency.
*/
`timescale 1ns/100ps
module poly_mod_mult #(
  parameter int                               WORD_BITS = 16,
  parameter int                               NUM_WORDS = 4,
  parameter logic [WORD_BITS*NUM_WORDS-1:0]   MODULUS   = 64'hE3B0_C442_98FC_1C15,
  parameter int                               I_WORD    = NUM_WORDS + 1,
  parameter int                               COEF_BITS = WORD_BITS + 1
) (
  input  logic             i_clk,
  input  logic             i_rst,
  input  vdf_pkg::sq_req_t i_req,
  output vdf_pkg::sq_rsp_t o_rsp
);

  localparam int COL_BITS = 2*COEF_BITS + $clog2(I_WORD) + 1;

  logic [2*I_WORD-1:0][COL_BITS-1:0] cols;    // combinational columns.
  vdf_pkg::col_vec_t                 cols_q;  // registered columns.
  logic                              val_q, ro_q, ro_q2;
  vdf_pkg::acc_vec_t                 lo_coef, hi_coef;
  logic                              lo_val, hi_val;

  // column k collects every a_i*a_j with i+j == k. off-diagonal pairs appear
  // twice in the square, so each is taken once and doubled.
  always_comb begin
    cols = '0;
    if (i_req.reduce_only) begin
      for (int k = 0; k < I_WORD; k++) cols[k] = COL_BITS'(i_req.dat[k]);  // high half stays zero.
    end else begin
      for (int i = 0; i < I_WORD; i++) begin
        for (int j = i; j < I_WORD; j++) begin
          if (i == j)
            cols[i+j] = cols[i+j] + COL_BITS'(i_req.dat[i]) * COL_BITS'(i_req.dat[j]);
          else
            cols[i+j] = cols[i+j] + ((COL_BITS'(i_req.dat[i]) * COL_BITS'(i_req.dat[j])) << 1);
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    cols_q <= cols;           // payload, no reset.
    ro_q   <= i_req.reduce_only;
    ro_q2  <= ro_q;           // lines up with the fold and reduce outputs.
    if (i_rst) val_q <= 1'b0;
    else       val_q <= i_req.val;
  end

  poly_carry_fold #(
    .WORD_BITS ( WORD_BITS ),
    .I_WORD    ( I_WORD    ),
    .COEF_BITS ( COEF_BITS )
  ) u_fold (
    .i_clk  ( i_clk                  ),
    .i_rst  ( i_rst                  ),
    .i_cols ( cols_q[I_WORD-1:0]     ),
    .i_val  ( val_q                  ),
    .o_coef ( lo_coef                ),
    .o_val  ( lo_val                 )
  );

  poly_mod_reduce_hi #(
    .WORD_BITS ( WORD_BITS ),
    .NUM_WORDS ( NUM_WORDS ),
    .MODULUS   ( MODULUS   ),
    .I_WORD    ( I_WORD    ),
    .COEF_BITS ( COEF_BITS )
  ) u_reduce_hi (
    .i_clk  ( i_clk                     ),
    .i_rst  ( i_rst                     ),
    .i_cols ( cols_q[2*I_WORD-1:I_WORD] ),
    .i_val  ( val_q                     ),
    .o_coef ( hi_coef                   ),
    .o_val  ( hi_val                    )
  );

  poly_coef_add #(
    .WORD_BITS ( WORD_BITS ),
    .I_WORD    ( I_WORD    ),
    .COEF_BITS ( COEF_BITS )
  ) u_coef_add (
    .i_clk         ( i_clk           ),
    .i_rst         ( i_rst           ),
    .i_lo          ( lo_coef         ),
    .i_hi          ( hi_coef         ),
    .i_val         ( lo_val & hi_val ),  // both sides run in lockstep.
    .i_reduce_only ( ro_q2           ),
    .o_rsp         ( o_rsp           )
  );

endmodule

// ==== poly_mod_mult/poly_coef_add.sv ====
/*
  Combines the folded low side and the reduced high side entry by entry and
  runs one carry pass. The low entries come out one word wide and the top
  entry carries the remaining magnitude for the final correction.
*/
`timescale 1ns/100ps
module poly_coef_add #(
  parameter int WORD_BITS = 16,
  parameter int I_WORD    = 5,
  parameter int COEF_BITS = WORD_BITS + 1
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  vdf_pkg::acc_vec_t i_lo,
  input  vdf_pkg::acc_vec_t i_hi,
  input  logic              i_val,
  input  logic              i_reduce_only,
  output vdf_pkg::sq_rsp_t  o_rsp
);

  localparam int COL_BITS = 2*COEF_BITS + $clog2(I_WORD) + 1;
  localparam int ACC_BITS = COL_BITS + WORD_BITS + $clog2(I_WORD) + 1;

  logic [I_WORD-1:0][ACC_BITS-1:0] coef;

  always_comb begin
    logic [ACC_BITS:0]   sum;
    logic [ACC_BITS-1:0] carry;
    carry = '0;
    for (int j = 0; j < I_WORD; j++) begin
      // in reduce-only mode the high side carries nothing, so it is left out.
      sum = (ACC_BITS+1)'(i_lo[j]) + (ACC_BITS+1)'(carry);
      if (!i_reduce_only) sum = sum + (ACC_BITS+1)'(i_hi[j]);
      if (j < I_WORD-1) begin
        coef[j] = ACC_BITS'(sum[WORD_BITS-1:0]);
        carry   = ACC_BITS'(sum >> WORD_BITS);
      end else begin
        coef[j] = ACC_BITS'(sum);  // the top sum is small enough to fit.
      end
    end
  end

  always_ff @(posedge i_clk) begin
    o_rsp.dat <= coef;
    if (i_rst) o_rsp.val <= 1'b0;
    else       o_rsp.val <= i_val;
  end

endmodule

// ==== poly_mod_mult/poly_mod_reduce_hi.sv ====
/*
  Reduces the high product columns under the modulus. Column weight
  2**(WORD_BITS*k) is replaced by its precomputed residue, split into words,
  and every column-by-word product lands in the matching coefficient.
*/
`timescale 1ns/100ps
module poly_mod_reduce_hi #(
  parameter int                             WORD_BITS = 16,
  parameter int                             NUM_WORDS = 4,
  parameter logic [WORD_BITS*NUM_WORDS-1:0] MODULUS   = 64'hE3B0_C442_98FC_1C15,
  parameter int                             I_WORD    = NUM_WORDS + 1,
  parameter int                             COEF_BITS = WORD_BITS + 1
) (
  input  logic               i_clk,
  input  logic               i_rst,
  input  vdf_pkg::col_half_t i_cols,
  input  logic               i_val,
  output vdf_pkg::acc_vec_t  o_coef,
  output logic               o_val
);

  localparam int COL_BITS  = 2*COEF_BITS + $clog2(I_WORD) + 1;
  localparam int ACC_BITS  = COL_BITS + WORD_BITS + $clog2(I_WORD) + 1;
  localparam int RES_BITS  = WORD_BITS*NUM_WORDS;
  localparam int PROD_BITS = COL_BITS + WORD_BITS;

  logic [I_WORD-1:0][NUM_WORDS-1:0][PROD_BITS-1:0] prod;  // column k times residue word w.
  logic [I_WORD-1:0][ACC_BITS-1:0]                 coef;

  for (genvar k = 0; k < I_WORD; k++) begin : g_col
    // high column k sits at weight 2**(WORD_BITS*(I_WORD+k)).
    localparam logic [RES_BITS-1:0] RES =
      RES_BITS'(vdf_pkg::residue_of(WORD_BITS*(I_WORD+k), 128'(MODULUS)));
    for (genvar w = 0; w < NUM_WORDS; w++) begin : g_word
      assign prod[k][w] = PROD_BITS'(i_cols[k]) * PROD_BITS'(RES[w*WORD_BITS +: WORD_BITS]);
    end
  end

  // residues are below the modulus, so they fill only NUM_WORDS coefficients.
  // the entries above stay zero.
  always_comb begin
    coef = '0;
    for (int w = 0; w < NUM_WORDS; w++) begin
      for (int k = 0; k < I_WORD; k++) begin
        coef[w] = coef[w] + ACC_BITS'(prod[k][w]);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    o_coef <= coef;
    if (i_rst) o_val <= 1'b0;
    else       o_val <= i_val;
  end

endmodule

// ==== poly_mod_mult/poly_carry_fold.sv ====
/*
  Normalizes the low product columns by rippling each column's upper bits
  into the next one. The value is kept exactly, with the top entry holding
  everything from its weight upward. One registered stage.
*/
`timescale 1ns/100ps
module poly_carry_fold #(
  parameter int WORD_BITS = 16,
  parameter int I_WORD    = 5,
  parameter int COEF_BITS = WORD_BITS + 1
) (
  input  logic               i_clk,
  input  logic               i_rst,
  input  vdf_pkg::col_half_t i_cols,
  input  logic               i_val,
  output vdf_pkg::acc_vec_t  o_coef,
  output logic               o_val
);

  localparam int COL_BITS = 2*COEF_BITS + $clog2(I_WORD) + 1;
  localparam int ACC_BITS = COL_BITS + WORD_BITS + $clog2(I_WORD) + 1;

  logic [I_WORD-1:0][ACC_BITS-1:0] coef;

  always_comb begin
    logic [ACC_BITS-1:0] acc;
    logic [ACC_BITS-1:0] carry;
    carry = '0;
    for (int j = 0; j < I_WORD-1; j++) begin
      acc     = ACC_BITS'(i_cols[j]) + carry;
      coef[j] = ACC_BITS'(acc[WORD_BITS-1:0]);  // keep one word here.
      carry   = acc >> WORD_BITS;               // the rest belongs one column up.
    end
    coef[I_WORD-1] = ACC_BITS'(i_cols[I_WORD-1]) + carry;  // top keeps its full overflow.
  end

  always_ff @(posedge i_clk) begin
    o_coef <= coef;
    if (i_rst) o_val <= 1'b0;
    else       o_val <= i_val;
  end

endmodule

// ==== common/vdf_pkg.sv ====
/*
  Shared types and constant functions for the modular squaring unit.
  Widths here follow the default size; modules derive their own widths from
  their parameters and refer to these types by scoped name.
*/
package vdf_pkg;

  localparam int WORD_BITS       = 16;                           // weight step between coefficients.
  localparam int NUM_WORDS       = 4;                            // words in the modulus.
  localparam int REDUN_WORD_BITS = 1;                            // redundant headroom per coefficient.
  localparam int I_WORD          = NUM_WORDS + 1;                // coefficients per operand.
  localparam int COEF_BITS       = WORD_BITS + REDUN_WORD_BITS;  // bits per input coefficient.
  localparam int COL_BITS        = 2*COEF_BITS + $clog2(I_WORD) + 1;  // one product column.
  localparam int ACC_BITS        = COL_BITS + WORD_BITS + $clog2(I_WORD) + 1;  // wide coefficient.

  typedef logic [I_WORD-1:0][COEF_BITS-1:0]   coef_vec_t;  // redundant operand.
  typedef logic [2*I_WORD-1:0][COL_BITS-1:0]  col_vec_t;   // all product columns.
  typedef logic [I_WORD-1:0][COL_BITS-1:0]    col_half_t;  // either half of the columns.
  typedef logic [I_WORD-1:0][ACC_BITS-1:0]    acc_vec_t;   // partially reduced coefficients.

  typedef struct packed {
    logic      val;          // word is consumed in this cycle.
    logic      reduce_only;  // skip the square and only reduce.
    coef_vec_t dat;
  } sq_req_t;

  typedef struct packed {
    logic     val;
    acc_vec_t dat;           // low entries hold WORD_BITS, the top entry carries the rest.
  } sq_rsp_t;

  typedef struct packed {
    logic                           val;
    logic [NUM_WORDS*WORD_BITS-1:0] dat;  // fully reduced result below the modulus.
  } int_rsp_t;

  // 2**p mod m, built by repeated doubling so it folds to a constant.
  function automatic logic [127:0] residue_of(input int unsigned p, input logic [127:0] m);
    logic [128:0] r;
    r = (m == 128'd1) ? 129'd0 : 129'd1;
    for (int unsigned i = 0; i < p; i++) begin
      r = r << 1;
      if (r >= {1'b0, m}) r = r - {1'b0, m};  // keep the running value below m.
    end
    return r[127:0];
  endfunction

  // floor(2**e / m) by restoring long division, used for the quotient estimate.
  function automatic logic [255:0] barrett_mu(input int e, input logic [127:0] m);
    logic [255:0] q;
    logic [128:0] rem;
    q   = '0;
    rem = '0;
    for (int i = e; i >= 0; i--) begin
      rem = {rem[127:0], (i == e)};  // the dividend is a single one at bit e.
      if (rem >= {1'b0, m}) begin
        rem  = rem - {1'b0, m};
        q[i] = 1'b1;
      end
    end
    return q;
  endfunction

endpackage
